/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [1:0]  size_t;
	typedef logic [4:0]  exccode_t;
	typedef logic [3:0]  byte_en_t;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RELEASE,
		DONE
	} mem_state_t;

	// Access sizes
	localparam size_t SIZE_BYTE = 2'd0;
	localparam size_t SIZE_HALF = 2'd1;
	localparam size_t SIZE_WORD = 2'd2;

	// Cause.ExcCode values
	localparam exccode_t EXC_ADEL = 5'd4;
	localparam exccode_t EXC_ADES = 5'd5;
	localparam exccode_t EXC_SYS  = 5'd8;
	localparam exccode_t EXC_BP   = 5'd9;
	localparam exccode_t EXC_RI   = 5'd10;
	localparam exccode_t EXC_OV   = 5'd12;

	// CP0 field positions
	localparam int STATUS_EXL    = 1;
	localparam int CAUSE_BD      = 31;
	localparam int CAUSE_EXC_LSB = 2;

endpackage

`default_nettype wire

/* rtl/data_addr_check.sv */
`timescale 1ns/1ns
`default_nettype none

module data_addr_check (
	input  logic            memreq,
	input  logic            wr,
	input  cpu_pkg::word_t  addr,
	input  cpu_pkg::size_t  size,
	input  logic            addr_err_if,
	input  cpu_pkg::word_t  pc,
	output cpu_pkg::word_t  badvaddr,
	output logic [1:0]      addr_err,
	output logic            data_ok
);

	logic misaligned;

	always_comb begin
		case (size)
			cpu_pkg::SIZE_HALF: misaligned = addr[0];
			cpu_pkg::SIZE_WORD: misaligned = addr[1:0] != 2'b00;
			default:            misaligned = 1'b0;
		endcase
	end

	// Bit 0 load error, bit 1 store error
	assign addr_err = memreq ? {misaligned & wr, misaligned & ~wr} : 2'b00;

	// Fetch error reports the instruction address
	assign badvaddr = addr_err_if ? pc : addr;
	assign data_ok  = memreq & ~misaligned & ~addr_err_if;

	always_comb begin
		assert ($onehot0(addr_err) && !(data_ok && addr_err != 2'b00));
	end

endmodule

`default_nettype wire

/* rtl/exc_handler.sv */
`timescale 1ns/1ns
`default_nettype none

module exc_handler #(
	parameter cpu_pkg::word_t EXC_VECTOR = 32'hbfc0_0380
) (
	input  logic               is_instr,
	input  logic               in_delay_slot,
	input  cpu_pkg::word_t     pc,
	input  cpu_pkg::word_t     badvaddr,
	input  logic               addr_err_if,
	input  logic [1:0]         addr_err,
	input  logic               reserved_instr,
	input  logic               intovf,
	input  logic               mips_break,
	input  logic               syscall,
	input  logic               eret,
	input  cpu_pkg::word_t     status,
	input  cpu_pkg::word_t     cause,
	input  cpu_pkg::word_t     epc,
	output logic               exc_valid,
	output cpu_pkg::exccode_t  exccode,
	output cpu_pkg::word_t     epc_wdata,
	output logic               cause_bd_wdata,
	output logic               badvaddr_wen,
	output cpu_pkg::word_t     badvaddr_wdata,
	output cpu_pkg::word_t     redirect_pc,
	output logic               eret_valid
);

	logic any_exc;
	logic adr_exc;

	// Highest priority first
	always_comb begin
		exccode = cpu_pkg::EXC_ADEL;
		adr_exc = 1'b0;
		if (addr_err_if) begin
			exccode = cpu_pkg::EXC_ADEL;
			adr_exc = 1'b1;
		end else if (reserved_instr) begin
			exccode = cpu_pkg::EXC_RI;
		end else if (intovf) begin
			exccode = cpu_pkg::EXC_OV;
		end else if (syscall) begin
			exccode = cpu_pkg::EXC_SYS;
		end else if (mips_break) begin
			exccode = cpu_pkg::EXC_BP;
		end else if (addr_err[0]) begin
			exccode = cpu_pkg::EXC_ADEL;
			adr_exc = 1'b1;
		end else if (addr_err[1]) begin
			exccode = cpu_pkg::EXC_ADES;
			adr_exc = 1'b1;
		end
	end

	assign any_exc = addr_err_if | reserved_instr | intovf | syscall | mips_break | (|addr_err);

	// Bubbles raise nothing
	assign exc_valid  = is_instr & any_exc;
	assign eret_valid = is_instr & eret & ~any_exc;

	assign epc_wdata      = in_delay_slot ? pc - 32'd4 : pc;
	// BD is frozen while already at exception level
	assign cause_bd_wdata = status[cpu_pkg::STATUS_EXL] ? cause[cpu_pkg::CAUSE_BD] : in_delay_slot;
	assign badvaddr_wen   = exc_valid & adr_exc;
	assign badvaddr_wdata = badvaddr;

	assign redirect_pc = exc_valid ? EXC_VECTOR : (eret_valid ? epc : '0);

	always_comb begin
		assert (!(exc_valid && eret_valid));
	end

endmodule

`default_nettype wire

/* rtl/sram_wsig_adjust.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_wsig_adjust (
	input  logic               req,
	input  logic               wr,
	input  cpu_pkg::word_t     data_in,
	input  cpu_pkg::size_t     size,
	input  logic [1:0]         offset,
	output cpu_pkg::word_t     data_out,
	output cpu_pkg::byte_en_t  be
);

	cpu_pkg::byte_en_t lanes;

	// Replicate so every lane carries the store data
	always_comb begin
		case (size)
			cpu_pkg::SIZE_BYTE: begin
				data_out = {4{data_in[7:0]}};
				lanes    = 4'b0001 << offset;
			end
			cpu_pkg::SIZE_HALF: begin
				data_out = {2{data_in[15:0]}};
				lanes    = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				data_out = data_in;
				lanes    = 4'b1111;
			end
		endcase
	end

	assign be = (req && wr) ? lanes : '0;

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage #(
	parameter cpu_pkg::word_t EXC_VECTOR = 32'hbfc0_0380
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               op_req,
	output logic               op_ack,
	input  cpu_pkg::word_t     pc,
	input  cpu_pkg::word_t     alu_out,
	input  cpu_pkg::word_t     rtdata,
	input  logic [4:0]         reg_waddr,
	input  logic               regwrite,
	input  logic               memtoreg,
	input  logic               memreq,
	input  logic               memwr,
	input  cpu_pkg::size_t     size,
	input  logic               in_delay_slot,
	input  logic               is_instr,
	input  logic               addr_err_if,
	input  logic               intovf,
	input  logic               reserved_instr,
	input  logic               mips_break,
	input  logic               syscall,
	input  logic               eret,
	output logic               data_req,
	output logic               data_wr,
	output cpu_pkg::word_t     data_addr,
	output cpu_pkg::word_t     data_wdata,
	output cpu_pkg::byte_en_t  data_be,
	input  logic               data_ack,
	input  cpu_pkg::word_t     data_rdata,
	input  cpu_pkg::word_t     cp0_epc,
	input  cpu_pkg::word_t     cp0_status,
	input  cpu_pkg::word_t     cp0_cause,
	output logic               exc_wen,
	output logic               eret_wen,
	output cpu_pkg::word_t     epc_wdata,
	output logic               cause_bd_wdata,
	output cpu_pkg::exccode_t  exccode_wdata,
	output logic               badvaddr_wen,
	output cpu_pkg::word_t     badvaddr_wdata,
	output logic               wb_valid,
	output logic [4:0]         wb_reg_waddr,
	output logic               wb_regwrite,
	output cpu_pkg::word_t     wb_data,
	output logic               exc_valid,
	output cpu_pkg::exccode_t  exc_code,
	output cpu_pkg::word_t     redirect_pc
);

	cpu_pkg::mem_state_t state;
	cpu_pkg::word_t      chk_badvaddr;
	cpu_pkg::word_t      adj_wdata;
	cpu_pkg::word_t      hdl_epc;
	cpu_pkg::word_t      hdl_badvaddr;
	cpu_pkg::word_t      hdl_redirect;
	cpu_pkg::exccode_t   hdl_code;
	cpu_pkg::byte_en_t   adj_be;
	logic [1:0]          addr_err;
	logic                data_ok;
	logic                hdl_exc;
	logic                hdl_eret;
	logic                hdl_bd;
	logic                hdl_bad_wen;
	logic                access_ok;
	logic                load_q;
	logic                eret_q;

	data_addr_check u_addr_check (
		.memreq      (memreq),
		.wr          (memwr),
		.addr        (alu_out),
		.size        (size),
		.addr_err_if (addr_err_if),
		.pc          (pc),
		.badvaddr    (chk_badvaddr),
		.addr_err    (addr_err),
		.data_ok     (data_ok)
	);

	exc_handler #(.EXC_VECTOR(EXC_VECTOR)) u_exc_handler (
		.is_instr       (is_instr),
		.in_delay_slot  (in_delay_slot),
		.pc             (pc),
		.badvaddr       (chk_badvaddr),
		.addr_err_if    (addr_err_if),
		.addr_err       (addr_err),
		.reserved_instr (reserved_instr),
		.intovf         (intovf),
		.mips_break     (mips_break),
		.syscall        (syscall),
		.eret           (eret),
		.status         (cp0_status),
		.cause          (cp0_cause),
		.epc            (cp0_epc),
		.exc_valid      (hdl_exc),
		.exccode        (hdl_code),
		.epc_wdata      (hdl_epc),
		.cause_bd_wdata (hdl_bd),
		.badvaddr_wen   (hdl_bad_wen),
		.badvaddr_wdata (hdl_badvaddr),
		.redirect_pc    (hdl_redirect),
		.eret_valid     (hdl_eret)
	);

	sram_wsig_adjust u_wsig_adjust (
		.req      (data_ok),
		.wr       (memwr),
		.data_in  (rtdata),
		.size     (size),
		.offset   (alu_out[1:0]),
		.data_out (adj_wdata),
		.be       (adj_be)
	);

	// Memory is touched only by a clean access
	assign access_ok     = data_ok & ~hdl_exc;
	assign op_ack        = state == cpu_pkg::DONE;
	assign exccode_wdata = exc_code;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= cpu_pkg::IDLE;
			data_req     <= 1'b0;
			wb_valid     <= 1'b0;
			exc_wen      <= 1'b0;
			eret_wen     <= 1'b0;
			badvaddr_wen <= 1'b0;
			exc_valid    <= 1'b0;
		end else begin
			wb_valid     <= 1'b0;
			exc_wen      <= 1'b0;
			eret_wen     <= 1'b0;
			badvaddr_wen <= 1'b0;
			case (state)
				cpu_pkg::IDLE: begin
					if (op_req) begin
						exc_valid <= hdl_exc;
						if (access_ok) begin
							state    <= cpu_pkg::ACCESS;
							data_req <= 1'b1;
						end else begin
							state        <= cpu_pkg::DONE;
							wb_valid     <= 1'b1;
							exc_wen      <= hdl_exc;
							eret_wen     <= hdl_eret;
							badvaddr_wen <= hdl_bad_wen;
						end
					end
				end
				cpu_pkg::ACCESS: begin
					if (data_ack) begin
						state    <= cpu_pkg::RELEASE;
						data_req <= 1'b0;
					end
				end
				cpu_pkg::RELEASE: begin
					if (!data_ack) begin
						state    <= cpu_pkg::DONE;
						wb_valid <= 1'b1;
						eret_wen <= eret_q;
					end
				end
				default: begin
					if (!op_req)
						state <= cpu_pkg::IDLE;
				end
			endcase
		end
	end

	// Operation and result payload
	always_ff @(posedge clk) begin
		if (state == cpu_pkg::IDLE && op_req) begin
			data_wr        <= memwr;
			data_addr      <= alu_out;
			data_wdata     <= adj_wdata;
			data_be        <= adj_be;
			wb_reg_waddr   <= reg_waddr;
			wb_regwrite    <= regwrite & ~hdl_exc;
			wb_data        <= alu_out;
			load_q         <= memtoreg;
			eret_q         <= hdl_eret;
			exc_code       <= hdl_code;
			redirect_pc    <= hdl_redirect;
			epc_wdata      <= hdl_epc;
			cause_bd_wdata <= hdl_bd;
			badvaddr_wdata <= hdl_badvaddr;
		end
		if (state == cpu_pkg::ACCESS && data_ack && load_q)
			wb_data <= data_rdata;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(data_req) |-> state == cpu_pkg::ACCESS);

endmodule

`default_nettype wire

/* rtl/cp0_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_regs (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               exc_wen,
	input  logic               eret_wen,
	input  cpu_pkg::word_t     epc_wdata,
	input  logic               cause_bd_wdata,
	input  cpu_pkg::exccode_t  exccode_wdata,
	input  logic               badvaddr_wen,
	input  cpu_pkg::word_t     badvaddr_wdata,
	output cpu_pkg::word_t     epc,
	output cpu_pkg::word_t     status,
	output cpu_pkg::word_t     cause,
	output cpu_pkg::word_t     badvaddr
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			epc      <= '0;
			status   <= '0;
			cause    <= '0;
			badvaddr <= '0;
		end else if (exc_wen) begin
			status[cpu_pkg::STATUS_EXL] <= 1'b1;
			cause[cpu_pkg::CAUSE_BD]    <= cause_bd_wdata;
			cause[cpu_pkg::CAUSE_EXC_LSB +: $bits(cpu_pkg::exccode_t)] <= exccode_wdata;
			// Nested exception keeps the first return address
			if (!status[cpu_pkg::STATUS_EXL])
				epc <= epc_wdata;
			if (badvaddr_wen)
				badvaddr <= badvaddr_wdata;
		end else if (eret_wen) begin
			status[cpu_pkg::STATUS_EXL] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               data_req,
	input  logic               data_wr,
	input  cpu_pkg::word_t     data_addr,
	input  cpu_pkg::word_t     data_wdata,
	input  cpu_pkg::byte_en_t  data_be,
	output logic               data_ack,
	output cpu_pkg::word_t     data_rdata
);

	localparam int IDX_W = $clog2(RAM_WORDS);

	cpu_pkg::word_t   mem [RAM_WORDS];
	logic [IDX_W-1:0] idx;

	// Word index, byte offset dropped
	assign idx = data_addr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (!rst_n)
			data_ack <= 1'b0;
		else
			data_ack <= data_req;
	end

	// Access happens once, in the cycle ack rises
	always_ff @(posedge clk) begin
		if (data_req && !data_ack) begin
			if (data_wr) begin
				for (int b = 0; b < 4; b++) begin
					if (data_be[b])
						mem[idx][8*b +: 8] <= data_wdata[8*b +: 8];
				end
			end else begin
				data_rdata <= mem[idx];
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		data_req && $past(data_req) |-> $stable(data_addr));

endmodule

`default_nettype wire

/* rtl/mem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_top #(
	parameter cpu_pkg::word_t EXC_VECTOR = 32'hbfc0_0380,
	parameter int             RAM_WORDS  = 256
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               op_req,
	output logic               op_ack,
	input  cpu_pkg::word_t     pc,
	input  cpu_pkg::word_t     alu_out,
	input  cpu_pkg::word_t     rtdata,
	input  logic [4:0]         reg_waddr,
	input  logic               regwrite,
	input  logic               memtoreg,
	input  logic               memreq,
	input  logic               memwr,
	input  cpu_pkg::size_t     size,
	input  logic               in_delay_slot,
	input  logic               is_instr,
	input  logic               addr_err_if,
	input  logic               intovf,
	input  logic               reserved_instr,
	input  logic               mips_break,
	input  logic               syscall,
	input  logic               eret,
	output logic               wb_valid,
	output logic [4:0]         wb_reg_waddr,
	output logic               wb_regwrite,
	output cpu_pkg::word_t     wb_data,
	output logic               exc_valid,
	output cpu_pkg::exccode_t  exc_code,
	output cpu_pkg::word_t     redirect_pc,
	output cpu_pkg::word_t     epc,
	output cpu_pkg::word_t     status,
	output cpu_pkg::word_t     cause,
	output cpu_pkg::word_t     badvaddr
);

	// Memory handshake
	logic               data_req;
	logic               data_wr;
	logic               data_ack;
	cpu_pkg::word_t     data_addr;
	cpu_pkg::word_t     data_wdata;
	cpu_pkg::word_t     data_rdata;
	cpu_pkg::byte_en_t  data_be;

	// CP0 write path
	logic               exc_wen;
	logic               eret_wen;
	logic               cause_bd_wdata;
	logic               badvaddr_wen;
	cpu_pkg::word_t     epc_wdata;
	cpu_pkg::word_t     badvaddr_wdata;
	cpu_pkg::exccode_t  exccode_wdata;

	mem_stage #(.EXC_VECTOR(EXC_VECTOR)) u_mem_stage (
		.cp0_epc    (epc),
		.cp0_status (status),
		.cp0_cause  (cause),
		.*
	);

	cp0_regs u_cp0_regs (.*);

	data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (.*);

endmodule

`default_nettype wire

/* bench/tb_mem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_top;

	localparam int N_WORDS    = 16;
	localparam int ALIGN_REPS = 4;
	localparam int PRIO_RUNS  = 40;
	localparam int PLAIN_RUNS = 12;
	// Upper bound, a priority run is followed by an ERET at most once
	localparam int NUM_OPS    = N_WORDS + 14 * ALIGN_REPS + 21 + 2 * PRIO_RUNS + 6
		+ 2 * PLAIN_RUNS;
	localparam int WATCHDOG_CYCLES = 10 + NUM_OPS * 20 + 200;

	localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;
	localparam logic [31:0] BASE       = 32'h0000_0100;
	localparam logic [4:0]  CODE_ADEL  = 5'd4;
	localparam logic [4:0]  CODE_ADES  = 5'd5;
	localparam logic [4:0]  CODE_SYS   = 5'd8;
	localparam logic [4:0]  CODE_BP    = 5'd9;
	localparam logic [4:0]  CODE_RI    = 5'd10;
	localparam logic [4:0]  CODE_OV    = 5'd12;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        op_req;
	logic        op_ack;
	logic [31:0] pc;
	logic [31:0] alu_out;
	logic [31:0] rtdata;
	logic [4:0]  reg_waddr;
	logic        regwrite;
	logic        memtoreg;
	logic        memreq;
	logic        memwr;
	logic [1:0]  size;
	logic        in_delay_slot;
	logic        is_instr;
	logic        addr_err_if;
	logic        intovf;
	logic        reserved_instr;
	logic        mips_break;
	logic        syscall;
	logic        eret;
	logic        wb_valid;
	logic [4:0]  wb_reg_waddr;
	logic        wb_regwrite;
	logic [31:0] wb_data;
	logic        exc_valid;
	logic [4:0]  exc_code;
	logic [31:0] redirect_pc;
	logic [31:0] epc;
	logic [31:0] status;
	logic [31:0] cause;
	logic [31:0] badvaddr;

	// Expected results of the operation in flight
	logic        exp_exc;
	logic        exp_eret;
	logic        exp_regwrite;
	logic [4:0]  exp_code;
	logic [4:0]  exp_waddr;
	logic [31:0] exp_redirect;
	logic [31:0] exp_data;

	// Shadow memory and CP0
	logic [31:0] s_mem [256];
	logic [31:0] s_epc = '0;
	logic [31:0] s_badvaddr = '0;
	logic [4:0]  s_excode = '0;
	logic        s_exl = 1'b0;
	logic        s_bd = 1'b0;

	int n_ops = 0;
	int n_compared = 0;
	int n_checks = 0;
	int n_errors = 0;

	mem_top mem_top_i (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
	endfunction

	function automatic void ref_model();
		logic       mis;
		logic       load_err;
		logic       store_err;
		logic       exc;
		logic       adr_win;
		logic [4:0] code;
		logic [7:0] idx;
		logic [1:0] lane;
		logic       en;
		logic [7:0] byte_v;
		mis = (size == 2'd1) ? alu_out[0] : ((size == 2'd2) ? (alu_out[1:0] != 2'b00) : 1'b0);
		load_err  = memreq & mis & ~memwr;
		store_err = memreq & mis & memwr;
		exc = addr_err_if | reserved_instr | intovf | syscall | mips_break | load_err | store_err;
		adr_win = 1'b0;
		code = 5'd0;
		if (addr_err_if) begin
			code = CODE_ADEL;
			adr_win = 1'b1;
		end else if (reserved_instr) begin
			code = CODE_RI;
		end else if (intovf) begin
			code = CODE_OV;
		end else if (syscall) begin
			code = CODE_SYS;
		end else if (mips_break) begin
			code = CODE_BP;
		end else if (load_err) begin
			code = CODE_ADEL;
			adr_win = 1'b1;
		end else if (store_err) begin
			code = CODE_ADES;
			adr_win = 1'b1;
		end
		exp_exc = exc;
		exp_code = code;
		exp_eret = eret & ~exc;
		exp_redirect = exc ? EXC_VECTOR : s_epc;
		exp_regwrite = regwrite & ~exc;
		exp_waddr = reg_waddr;
		exp_data = alu_out;
		idx = alu_out[9:2];
		if (exc) begin
			// EPC and BD only change on the first exception
			if (!s_exl) begin
				s_epc = in_delay_slot ? pc - 32'd4 : pc;
				s_bd = in_delay_slot;
			end
			s_excode = code;
			s_exl = 1'b1;
			if (adr_win)
				s_badvaddr = addr_err_if ? pc : alu_out;
		end else begin
			if (eret)
				s_exl = 1'b0;
			if (memreq && memwr) begin
				for (int b = 0; b < 4; b++) begin
					lane = 2'(b);
					case (size)
						2'd0: begin
							en = lane == alu_out[1:0];
							byte_v = rtdata[7:0];
						end
						2'd1: begin
							en = lane[1] == alu_out[1];
							byte_v = rtdata[8 * (b % 2) +: 8];
						end
						default: begin
							en = 1'b1;
							byte_v = rtdata[8 * b +: 8];
						end
					endcase
					if (en)
						s_mem[idx][8 * b +: 8] = byte_v;
				end
			end else if (memreq && memtoreg) begin
				exp_data = s_mem[idx];
			end
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("** Error at %0t ns: %s expected %08h, actual %08h",
				$time, name, expected, actual);
		end
	endtask

	task automatic clear_op();
		logic [31:0] r;
		r = $urandom();
		pc = 32'h8000_0000 | {12'b0, r[19:2], 2'b00};
		alu_out = $urandom();
		rtdata = $urandom();
		reg_waddr = r[24:20];
		regwrite = 1'b0;
		memtoreg = 1'b0;
		memreq = 1'b0;
		memwr = 1'b0;
		size = 2'd2;
		in_delay_slot = 1'b0;
		is_instr = 1'b1;
		addr_err_if = 1'b0;
		intovf = 1'b0;
		reserved_instr = 1'b0;
		mips_break = 1'b0;
		syscall = 1'b0;
		eret = 1'b0;
	endtask

	// Called on a falling edge with the fields already set
	task automatic issue_op();
		ref_model();
		n_ops++;
		op_req = 1'b1;
		do
			@(negedge clk);
		while (!op_ack);
		op_req = 1'b0;
		do
			@(negedge clk);
		while (op_ack);
		@(negedge clk);
	endtask

	task automatic mem_op(input logic wr, input logic [1:0] sz, input logic [31:0] addr,
			input logic [31:0] wdata);
		clear_op();
		memreq = 1'b1;
		memwr = wr;
		memtoreg = ~wr;
		regwrite = ~wr;
		size = sz;
		alu_out = addr;
		rtdata = wdata;
		issue_op();
	endtask

	task automatic eret_op();
		clear_op();
		eret = 1'b1;
		issue_op();
	endtask

	always begin
		@(posedge op_ack);
		@(negedge clk);
		check_value("wb_valid", 32'(wb_valid), 32'd1);
		check_value("exc_valid", 32'(exc_valid), 32'(exp_exc));
		check_value("wb_regwrite", 32'(wb_regwrite), 32'(exp_regwrite));
		check_value("wb_reg_waddr", 32'(wb_reg_waddr), 32'(exp_waddr));
		check_value("wb_data", wb_data, exp_data);
		if (exp_exc)
			check_value("exc_code", 32'(exc_code), 32'(exp_code));
		if (exp_exc || exp_eret)
			check_value("redirect_pc", redirect_pc, exp_redirect);
		// CP0 takes the strobes one cycle after op_ack rises
		@(negedge op_ack);
		@(negedge clk);
		check_value("epc", epc, s_epc);
		check_value("status", status, {30'b0, s_exl, 1'b0});
		check_value("cause", cause, {s_bd, 24'b0, s_excode, 2'b00});
		check_value("badvaddr", badvaddr, s_badvaddr);
		n_compared++;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] word;
		logic [1:0]  off;
		int          sel;
		void'($urandom(32'h7998));
		rst_n = 1'b0;
		op_req = 1'b0;
		clear_op();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		for (int w = 0; w < N_WORDS; w++)
			mem_op(1'b1, 2'd2, BASE + 32'(4 * w), fill_word(BASE + 32'(4 * w)));

		// Aligned stores of every size and offset
		for (int i = 0; i < ALIGN_REPS; i++) begin
			r = $urandom();
			word = BASE + {26'b0, r[3:0], 2'b00};
			for (int k = 0; k < 7; k++) begin
				off = (k < 4) ? 2'(k) : ((k < 6) ? 2'(2 * (k - 4)) : 2'd0);
				mem_op(1'b1, (k < 4) ? 2'd0 : ((k < 6) ? 2'd1 : 2'd2), word + {30'b0, off},
					$urandom());
				mem_op(1'b0, 2'd2, word, 32'd0);
			end
		end

		// Misaligned loads, then stores
		for (int k = 0; k < 10; k++) begin
			r = $urandom();
			word = BASE + {26'b0, r[3:0], 2'b00};
			sel = k % 5;
			off = (sel < 2) ? 2'(2 * sel + 1) : 2'(sel - 1);
			mem_op(k >= 5, (sel < 2) ? 2'd1 : 2'd2, word + {30'b0, off}, $urandom());
			mem_op(1'b0, 2'd2, word, 32'd0);
		end
		eret_op();

		for (int i = 0; i < PRIO_RUNS; i++) begin
			clear_op();
			r = $urandom();
			addr_err_if = r[0];
			reserved_instr = r[1];
			intovf = r[2];
			syscall = r[3];
			mips_break = r[4];
			in_delay_slot = r[8];
			regwrite = 1'b1;
			if (r[5]) begin
				memreq = 1'b1;
				memwr = r[6];
				memtoreg = ~r[6];
				size = r[7] ? 2'd1 : 2'd2;
				alu_out = BASE + {26'b0, r[13:10], 2'b01};
			end
			issue_op();
			if (r[9])
				eret_op();
		end

		// Delay slot, nested exception, ERET
		eret_op();
		clear_op();
		in_delay_slot = 1'b1;
		syscall = 1'b1;
		issue_op();
		clear_op();
		mips_break = 1'b1;
		issue_op();
		eret_op();
		clear_op();
		intovf = 1'b1;
		issue_op();
		eret_op();

		// No memory request, a stray write would show on the load
		for (int i = 0; i < PLAIN_RUNS; i++) begin
			clear_op();
			r = $urandom();
			alu_out = BASE + {26'b0, r[3:0], 2'b00};
			memwr = 1'b1;
			regwrite = r[4];
			word = alu_out;
			issue_op();
			mem_op(1'b0, 2'd2, word, 32'd0);
		end

		if (n_compared != n_ops) begin
			$display("Only %0d of %0d operations were compared", n_compared, n_ops);
			n_errors++;
		end
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
rtl/cpu_pkg.sv
rtl/data_addr_check.sv
rtl/exc_handler.sv
rtl/sram_wsig_adjust.sv
rtl/mem_stage.sv
rtl/cp0_regs.sv
rtl/data_ram.sv
rtl/mem_top.sv
bench/tb_mem_top.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_top -f sources.f \
	-Mdir obj_dir -o sim_mem_top > build.log 2>&1 \
	&& ./obj_dir/sim_mem_top > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
